// File: flist.f
src/isa_pkg.sv
src/pipe_pkg.sv
src/exu_reg.sv
src/alu.sv
src/lsu.sv
src/exu_top.sv
verification/tb_exu.sv

// File: run.sh
#!/bin/sh
# builds the execute subsystem testbench with Verilator, runs it and checks the outcome
verilator --binary --timing --top-module tb_exu -f flist.f -o tb_exu_sim \
  && ./obj_dir/tb_exu_sim | tee /dev/stderr | grep -q "Verification passed" \
  && echo "run.sh: simulation ok" \
  || { echo "run.sh: simulation not ok"; exit 1; }

// File: verification/tb_exu.sv
module tb_exu
  import isa_pkg::*, pipe_pkg::*;
;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 10;
  localparam int MAX_GAP      = 4;
  localparam int TOTAL_INSTR  = 200 + 20 + 72 + 4 + 300;
  localparam int MARGIN       = 200;
  localparam int TIMEOUT      = (RESET_CYCLES + TOTAL_INSTR * (MAX_GAP + 1) + MARGIN) * CLK_PERIOD;
  localparam logic [31:0] SEED = 32'h07bb60e0;

  typedef struct packed {
    int  due;                                      // cycle in which the writeback must show up
    wb_t wb;
  } exp_t;

  logic       clk;
  logic       rst;
  logic       issue_valid_i;
  exu_issue_t issue_i;
  logic       wb_valid_o;
  wb_t        wb_o;

  logic [31:0] model_mem [DMEM_WORDS];
  exp_t        exp_q [$];
  wb_t         last_wb;
  int          cyc;
  int          errors;
  int          checks;
  int          tests_run;
  int          err_mark;

  lsu_op_e st_ops [3] = '{LSU_SB, LSU_SH, LSU_SW};
  lsu_op_e ld_ops [5] = '{LSU_LB, LSU_LBU, LSU_LH, LSU_LHU, LSU_LW};

  exu_top DUT (
    .clk           (clk),
    .rst           (rst),
    .issue_valid_i (issue_valid_i),
    .issue_i       (issue_i),
    .wb_valid_o    (wb_valid_o),
    .wb_o          (wb_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cyc++;
  end

  function automatic int word_index(input logic [31:0] addr);
    return int'((addr >> 2) % DMEM_WORDS);         // memory wraps on the word index
  endfunction

  function automatic logic [31:0] ref_alu(input exu_issue_t it);
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  sh;
    a  = (it.inst_type == INST_AUIPC) ? it.pc : it.rdata1;
    b  = (it.inst_type == INST_R) ? it.rdata2 : it.imm;
    sh = b[4:0];
    if (it.inst_type == INST_LUI) begin
      return it.imm;
    end
    case (it.alu_op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a + ~b + 32'd1;
      ALU_SLL:  return a << sh;
      ALU_SLT:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
      ALU_SLTU: return {31'b0, a < b};
      ALU_XOR:  return a ^ b;
      ALU_SRL:  return a >> sh;
      ALU_SRA:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      default:  return 32'h0;
    endcase
  endfunction

  function automatic logic [31:0] ref_load(input exu_issue_t it);
    logic [31:0] addr;
    logic [31:0] word;
    logic [7:0]  byte_v;
    logic [15:0] half;
    addr   = it.rdata1 + it.imm;
    word   = model_mem[word_index(addr)];
    byte_v = word[8*addr[1:0] +: 8];
    half   = addr[1] ? word[31:16] : word[15:0];
    case (it.lsu_op)
      LSU_LB:  return {{24{byte_v[7]}}, byte_v};
      LSU_LBU: return {24'h0, byte_v};
      LSU_LH:  return {{16{half[15]}}, half};
      LSU_LHU: return {16'h0, half};
      LSU_LW:  return word;
      default: return 32'h0;
    endcase
  endfunction

  function automatic wb_t expect_wb(input exu_issue_t it);
    wb_t w;
    w.wena  = it.wena;
    w.waddr = it.waddr;
    w.wdata = it.wsel ? ref_load(it) : ref_alu(it);
    return w;
  endfunction

  function automatic void model_store(input exu_issue_t it);
    logic [31:0] addr;
    int          idx;
    addr = it.rdata1 + it.imm;
    idx  = word_index(addr);
    case (it.lsu_op)
      LSU_SB: model_mem[idx][8*addr[1:0] +: 8] = it.rdata2[7:0];
      LSU_SH: begin
        if (addr[1]) begin
          model_mem[idx][31:16] = it.rdata2[15:0];
        end else begin
          model_mem[idx][15:0] = it.rdata2[15:0];
        end
      end
      LSU_SW: model_mem[idx] = it.rdata2;
      default: ;
    endcase
  endfunction

  function automatic exu_issue_t random_alu_issue();
    exu_issue_t it;
    it           = '0;
    it.inst_type = $urandom_range(0, 1) ? INST_R : INST_I;
    it.alu_op    = alu_op_e'(4'($urandom_range(0, 9)));
    it.lsu_op    = LSU_NONE;
    it.wena      = 1'($urandom);
    it.waddr     = 5'($urandom);
    it.pc        = $urandom;
    it.imm       = $urandom;
    it.rdata1    = $urandom;
    it.rdata2    = ($urandom_range(0, 7) == 0) ? it.rdata1 : $urandom;  // equal operands now and then
    return it;
  endfunction

  function automatic exu_issue_t make_mem(input lsu_op_e op, input logic [31:0] base,
                                          input logic [31:0] off, input logic [31:0] data);
    exu_issue_t it;
    it           = '0;
    it.inst_type = (op == LSU_SB || op == LSU_SH || op == LSU_SW) ? INST_STORE : INST_LOAD;
    it.alu_op    = ALU_ADD;
    it.lsu_op    = op;
    it.wsel      = (it.inst_type == INST_LOAD);
    it.wena      = it.wsel;
    it.waddr     = 5'($urandom);
    it.pc        = $urandom;
    it.imm       = off;
    it.rdata1    = base;
    it.rdata2    = data;
    return it;
  endfunction

  function automatic exu_issue_t random_mixed_issue();
    exu_issue_t it;
    it = random_alu_issue();
    case ($urandom_range(0, 5))
      0: it.inst_type = INST_LUI;
      1: begin
        it.inst_type = INST_AUIPC;
        it.alu_op    = ALU_ADD;
      end
      2: it = make_mem(ld_ops[$urandom_range(0, 4)], 32'($urandom_range(0, 63)),
                       32'($urandom_range(0, 31)), $urandom);
      3: it = make_mem(st_ops[$urandom_range(0, 2)], 32'($urandom_range(0, 63)),
                       32'($urandom_range(0, 31)), $urandom);
      default: ;
    endcase
    return it;
  endfunction

  task automatic send(input exu_issue_t it);
    exp_t e;
    @(posedge clk);
    #1;
    issue_valid_i = 1'b1;
    issue_i       = it;
    e.due         = cyc + 2;                        // sampled at the next edge, written back one later
    e.wb          = expect_wb(it);
    exp_q.push_back(e);
    model_store(it);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      issue_valid_i = 1'b0;
      issue_i       = random_alu_issue();
    end
  endtask

  // stores sit on the bus without a strobe and must not reach memory
  task automatic idle_store_junk(input int n, input logic [31:0] addr);
    repeat (n) begin
      @(posedge clk);
      #1;
      issue_valid_i = 1'b0;
      issue_i       = make_mem(st_ops[$urandom_range(0, 2)], addr,
                               32'($urandom_range(0, 3)), $urandom);
    end
  endtask

  task automatic end_test(input string name);
    idle(1);
    while (exp_q.size() != 0) begin
      idle(1);
    end
    idle(2);
    tests_run++;
    $display("test %s finished with %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  initial begin : compare
    exp_t e;
    forever begin
      @(negedge clk);
      checks++;
      if (!rst && (wb_valid_o !== 1'b0 || wb_o !== '0)) begin
        errors++;
        $display("mismatch at %0t: writeback outputs not cleared during reset", $time);
      end
      if (wb_valid_o === 1'b1) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("error at %0t: writeback seen with no instruction outstanding", $time);
        end else begin
          e = exp_q.pop_front();
          if (cyc != e.due) begin
            errors++;
            $display("mismatch at %0t: writeback in cycle %0d, expected cycle %0d",
                     $time, cyc, e.due);
          end
          if (wb_o !== e.wb) begin
            errors++;
            $display("mismatch at %0t: expected wena %0b waddr %0d wdata %08h, got %0b %0d %08h",
                     $time, e.wb.wena, e.wb.waddr, e.wb.wdata, wb_o.wena, wb_o.waddr, wb_o.wdata);
          end
        end
        last_wb = wb_o;
      end else if (wb_o !== last_wb) begin
        errors++;
        $display("mismatch at %0t: writeback payload changed without a strobe", $time);
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT);
    $display("error: run did not finish within %0t, %0d writebacks outstanding",
             $time, exp_q.size());
    $display("Verification failed");
    $finish;
  end

  initial begin : stimulus
    exu_issue_t  it;
    logic [31:0] base;
    logic [31:0] data;
    logic [31:0] wrap;
    int          gap;
    void'($urandom(SEED));
    rst           = 1'b0;
    issue_valid_i = 1'b0;
    issue_i       = '0;
    last_wb       = '0;
    for (int w = 0; w < DMEM_WORDS; w++) begin
      model_mem[w] = 32'h0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b1;
    idle(5);
    end_test("reset_state");

    for (int i = 0; i < 200; i++) begin
      it = random_alu_issue();
      if (i < 10) begin
        it.alu_op = alu_op_e'(4'(i));               // every operation at least once
      end
      send(it);
      gap = $urandom_range(0, 1) ? 0 : $urandom_range(1, MAX_GAP);
      idle(gap);
    end
    end_test("alu_ops");

    for (int i = 0; i < 20; i++) begin
      it           = random_alu_issue();
      it.inst_type = (i < 10) ? INST_LUI : INST_AUIPC;
      it.alu_op    = (i < 10) ? it.alu_op : ALU_ADD;
      send(it);
      idle($urandom_range(0, 1));
    end
    end_test("lui_auipc");

    for (int s = 0; s < 3; s++) begin
      for (int off = 0; off < 4; off++) begin
        base = 32'($urandom_range(0, DMEM_WORDS - 1)) << 2;
        wrap = 32'($urandom_range(1, 15)) * 32'(DMEM_WORDS * 4);
        data = $urandom;
        data = off[0] ? (data | 32'h8080_8080) : (data & 32'h7f7f_7f7f);
        send(make_mem(st_ops[s], base + wrap, 32'(off), data));
        for (int l = 0; l < 5; l++) begin
          send(make_mem(ld_ops[l], base, 32'(off), $urandom));
        end
      end
    end
    end_test("store_load_widths");

    base = 32'h0000_0040;
    send(make_mem(LSU_SW, base, 32'h0, $urandom));
    idle_store_junk(MAX_GAP, base);
    send(make_mem(LSU_LW, base, 32'h0, 32'h0));
    idle_store_junk(MAX_GAP, base);
    send(make_mem(LSU_LBU, base, 32'h3, 32'h0));
    idle(MAX_GAP);
    send(make_mem(LSU_LH, base, 32'h2, 32'h0));
    end_test("hold_without_strobe");

    for (int i = 0; i < 300; i++) begin
      send(random_mixed_issue());
      idle($urandom_range(0, 2));
    end
    end_test("mixed_stream");

    if (exp_q.size() != 0) begin
      $display("error: %0d expected writebacks never arrived", exp_q.size());
    end
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0 && exp_q.size() == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: src/exu_top.sv
module exu_top
  import isa_pkg::*, pipe_pkg::*;
(
  input  logic       clk,
  input  logic       rst,

  input  logic       issue_valid_i,
  input  exu_issue_t issue_i,

  output logic       wb_valid_o,      // one cycle per completed instruction
  output wb_t        wb_o
);

  logic            ex_valid;
  exu_issue_t      ex_issue;
  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] load_data;
  wb_t             wb_next;

  exu_reg u_exu_reg (
    .clk           (clk),
    .rst           (rst),
    .issue_valid_i (issue_valid_i),
    .issue_i       (issue_i),
    .valid_o       (ex_valid),
    .issue_o       (ex_issue)
  );

  alu u_alu (
    .issue_i  (ex_issue),
    .result_o (alu_result)
  );

  // the alu sum doubles as the effective address
  lsu u_lsu (
    .clk      (clk),
    .rst      (rst),
    .valid_i  (ex_valid),
    .lsu_op_i (ex_issue.lsu_op),
    .addr_i   (alu_result),
    .wdata_i  (ex_issue.rdata2),
    .rdata_o  (load_data)
  );

  assign wb_next.wena  = ex_issue.wena;
  assign wb_next.waddr = ex_issue.waddr;
  assign wb_next.wdata = ex_issue.wsel ? load_data : alu_result;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      wb_valid_o <= 1'b0;
    end else begin
      wb_valid_o <= ex_valid;
    end
  end

  // writeback payload only moves when an instruction leaves execute
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      wb_o <= '0;
    end else if (ex_valid) begin
      wb_o <= wb_next;
    end
  end

endmodule

// File: src/lsu.sv
module lsu
  import isa_pkg::*;
(
  input  logic            clk,
  input  logic            rst,

  input  logic            valid_i,     // the staged instruction is live this cycle
  input  lsu_op_e         lsu_op_i,
  input  logic [XLEN-1:0] addr_i,
  input  logic [XLEN-1:0] wdata_i,
  output logic [XLEN-1:0] rdata_o
);

  logic [XLEN-1:0]           mem [DMEM_WORDS];

  logic [DMEM_AW-1:0]        word_idx;
  logic [1:0]                lane;
  logic [XLEN-1:0]           rd_word;
  logic [7:0]                rd_byte;
  logic [15:0]               rd_half;
  logic [BYTES_PER_WORD-1:0] wr_mask;
  logic [XLEN-1:0]           wr_word;

  // low two bits select the lane, upper bits wrap around the memory depth
  assign word_idx = addr_i[DMEM_AW+1:2];
  assign lane     = addr_i[1:0];

  assign rd_word  = mem[word_idx];
  assign rd_byte  = rd_word[8*lane +: 8];
  assign rd_half  = addr_i[1] ? rd_word[31:16] : rd_word[15:0];   // bit 0 is ignored

  always_comb begin
    unique case (lsu_op_i)
      LSU_LB:  rdata_o = {{(XLEN-8){rd_byte[7]}}, rd_byte};
      LSU_LBU: rdata_o = {{(XLEN-8){1'b0}}, rd_byte};
      LSU_LH:  rdata_o = {{(XLEN-16){rd_half[15]}}, rd_half};
      LSU_LHU: rdata_o = {{(XLEN-16){1'b0}}, rd_half};
      LSU_LW:  rdata_o = rd_word;
      default: rdata_o = '0;
    endcase
  end

  // store data is replicated across lanes so the mask alone picks the target
  always_comb begin
    wr_mask = '0;
    wr_word = '0;
    unique case (lsu_op_i)
      LSU_SB: begin
        wr_mask[lane] = 1'b1;
        wr_word       = {BYTES_PER_WORD{wdata_i[7:0]}};
      end
      LSU_SH: begin
        wr_mask = addr_i[1] ? HALF_HI_MASK : HALF_LO_MASK;
        wr_word = {2{wdata_i[15:0]}};
      end
      LSU_SW: begin
        wr_mask = '1;
        wr_word = wdata_i;
      end
      default: begin
        wr_mask = '0;
      end
    endcase
  end

  // memory starts out cleared, writes land at the end of the execute cycle
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int w = 0; w < DMEM_WORDS; w++) begin
        mem[w] <= '0;
      end
    end else if (valid_i) begin
      for (int b = 0; b < BYTES_PER_WORD; b++) begin
        if (wr_mask[b]) begin
          mem[word_idx][8*b +: 8] <= wr_word[8*b +: 8];
        end
      end
    end
  end

endmodule

// File: src/alu.sv
module alu
  import isa_pkg::*, pipe_pkg::*;
(
  input  exu_issue_t      issue_i,
  output logic [XLEN-1:0] result_o
);

  logic [XLEN-1:0]    op_a;
  logic [XLEN-1:0]    op_b;
  logic [SHAMT_W-1:0] shamt;

  // auipc works relative to the pc, everything else on rs1
  assign op_a = (issue_i.inst_type == INST_AUIPC) ? issue_i.pc : issue_i.rdata1;

  always_comb begin
    unique case (issue_i.inst_type)
      INST_I, INST_LOAD, INST_STORE, INST_LUI, INST_AUIPC: op_b = issue_i.imm;
      default:                                             op_b = issue_i.rdata2;
    endcase
  end

  assign shamt = op_b[SHAMT_W-1:0];

  always_comb begin
    if (issue_i.inst_type == INST_LUI) begin
      result_o = issue_i.imm;                          // lui passes the upper immediate
    end else begin
      unique case (issue_i.alu_op)
        ALU_ADD:  result_o = op_a + op_b;              // also the load and store address
        ALU_SUB:  result_o = op_a - op_b;
        ALU_SLL:  result_o = op_a << shamt;
        ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
        ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, op_a < op_b};
        ALU_XOR:  result_o = op_a ^ op_b;
        ALU_SRL:  result_o = op_a >> shamt;
        ALU_SRA:  result_o = $unsigned($signed(op_a) >>> shamt);
        ALU_OR:   result_o = op_a | op_b;
        ALU_AND:  result_o = op_a & op_b;
        default:  result_o = '0;
      endcase
    end
  end

endmodule

// File: src/exu_reg.sv
module exu_reg
  import pipe_pkg::*;
(
  input  logic       clk,
  input  logic       rst,

  input  logic       issue_valid_i,     // one cycle per decoded instruction
  input  exu_issue_t issue_i,

  output logic       valid_o,
  output exu_issue_t issue_o
);

  // valid only lasts for the cycle after a strobe
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= issue_valid_i;
    end
  end

  // payload is loaded on a strobe and held otherwise
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      issue_o <= '0;
    end else if (issue_valid_i) begin
      issue_o <= issue_i;
    end
  end

endmodule

// File: src/pipe_pkg.sv
package pipe_pkg;

  import isa_pkg::*;

  // one decoded instruction as handed from decode to execute
  typedef struct packed {
    inst_type_e            inst_type;
    alu_op_e               alu_op;
    lsu_op_e               lsu_op;
    logic                  wsel;       // 1 takes the load data, 0 the alu result
    logic                  wena;       // destination register is written
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       imm;        // already sign extended by decode
    logic [XLEN-1:0]       rdata1;     // rs1 value
    logic [XLEN-1:0]       rdata2;     // rs2 value, also the store data
  } exu_issue_t;

  // one register file write as presented by the execute subsystem
  typedef struct packed {
    logic                  wena;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
  } wb_t;

endpackage

// File: src/isa_pkg.sv
package isa_pkg;

  // data path and register index widths
  localparam int XLEN           = 32;
  localparam int REG_ADDR_W     = 5;
  localparam int BYTES_PER_WORD = XLEN / 8;
  localparam int SHAMT_W        = $clog2(XLEN);    // shifts use the low bits of operand b

  // data memory geometry, depth counted in 32-bit words
  localparam int DMEM_WORDS     = 64;
  localparam int DMEM_AW        = $clog2(DMEM_WORDS);

  // instruction class, decides operand selection in the alu
  typedef enum logic [2:0] {
    INST_R     = 3'd0,                              // reg-reg arithmetic
    INST_I     = 3'd1,                              // reg-imm arithmetic
    INST_LOAD  = 3'd2,
    INST_STORE = 3'd3,
    INST_LUI   = 3'd4,
    INST_AUIPC = 3'd5
  } inst_type_e;

  // alu operation, loads and stores arrive as add
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  // memory operation
  typedef enum logic [3:0] {
    LSU_NONE = 4'd0,
    LSU_LB   = 4'd1,                                // byte load, sign extended
    LSU_LH   = 4'd2,                                // half load, sign extended
    LSU_LW   = 4'd3,
    LSU_LBU  = 4'd4,                                // byte load, zero extended
    LSU_LHU  = 4'd5,                                // half load, zero extended
    LSU_SB   = 4'd6,
    LSU_SH   = 4'd7,
    LSU_SW   = 4'd8
  } lsu_op_e;

  // byte enables for the two halves of a word
  localparam logic [BYTES_PER_WORD-1:0] HALF_LO_MASK = 4'b0011;
  localparam logic [BYTES_PER_WORD-1:0] HALF_HI_MASK = 4'b1100;

endpackage
